// ==== rtl/exu_pkg.sv ====
package exu_pkg;

    localparam int REG_ADDR_W = 5;  // register index width

    // decoded opcodes seen by the execute stage
    typedef enum logic [4:0] {
        // integer alu
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_SLT,
        OP_SLTU,
        OP_ADDI,
        // branches and jumps
        OP_BEQ,
        OP_BNE,
        OP_BLT,
        OP_BGE,
        OP_BLTU,
        OP_BGEU,
        OP_JAL,
        OP_JALR,
        // unsigned multiply / divide
        OP_MUL,
        OP_MULHU,
        OP_DIVU,
        OP_REMU
    } exu_op_e;

endpackage

// ==== rtl/exu_req_if.sv ====
interface exu_req_if
    import exu_pkg::*;
#(
    parameter int XLEN = 32
) ();

    logic                  req;  // single-cycle strobe
    exu_op_e               op;
    logic [XLEN-1:0]       op1;
    logic [XLEN-1:0]       op2;
    logic [REG_ADDR_W-1:0] rd;   // destination register

    modport disp (output req, op, op1, op2, rd);
    modport unit (input req, op, op1, op2, rd);

endinterface

// ==== rtl/exu_dispatch.sv ====
module exu_dispatch
    import exu_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic                  valid_i,
    input  exu_op_e               op_i,
    input  logic [XLEN-1:0]       pc_i,
    input  logic [XLEN-1:0]       rs1_i,
    input  logic [XLEN-1:0]       rs2_i,
    input  logic [XLEN-1:0]       imm_i,
    input  logic [REG_ADDR_W-1:0] rd_i,
    exu_req_if.disp               alu_o,
    exu_req_if.disp               md_o
);

    logic is_alu;
    logic is_link;  // jal / jalr write pc+4 to rd
    logic is_md;

    // opcode grouping
    always_comb begin
        is_alu  = 1'b0;
        is_link = 1'b0;
        is_md   = 1'b0;
        case (op_i)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL, OP_SRL, OP_SRA,
            OP_SLT, OP_SLTU, OP_ADDI: is_alu = 1'b1;
            OP_JAL, OP_JALR:          is_link = 1'b1;
            OP_MUL, OP_MULHU, OP_DIVU, OP_REMU: is_md = 1'b1;
            default: ;  // plain branches only need the bru
        endcase
    end

    // alu request, jumps become a link add
    assign alu_o.req = valid_i & (is_alu | is_link);
    assign alu_o.op  = is_link ? OP_ADD : op_i;
    assign alu_o.op1 = is_link ? pc_i : rs1_i;
    assign alu_o.op2 = is_link ? XLEN'(4) : ((op_i == OP_ADDI) ? imm_i : rs2_i);
    assign alu_o.rd  = rd_i;

    // muldiv request
    assign md_o.req = valid_i & is_md;
    assign md_o.op  = op_i;
    assign md_o.op1 = rs1_i;
    assign md_o.op2 = rs2_i;
    assign md_o.rd  = rd_i;

endmodule

// ==== rtl/exu_alu.sv ====
module exu_alu
    import exu_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic                  clk,
    input  logic                  reset_i,
    exu_req_if.unit               req_i,
    output logic                  we_o,
    output logic [REG_ADDR_W-1:0] waddr_o,
    output logic [XLEN-1:0]       wdata_o
);

    logic [4:0]      shamt;
    logic [XLEN-1:0] result;

    assign shamt = req_i.op2[4:0];  // rv32 shift amount

    always_comb begin
        case (req_i.op)
            OP_ADD, OP_ADDI: result = req_i.op1 + req_i.op2;
            OP_SUB:  result = req_i.op1 - req_i.op2;
            OP_AND:  result = req_i.op1 & req_i.op2;
            OP_OR:   result = req_i.op1 | req_i.op2;
            OP_XOR:  result = req_i.op1 ^ req_i.op2;
            OP_SLL:  result = req_i.op1 << shamt;
            OP_SRL:  result = req_i.op1 >> shamt;
            OP_SRA:  result = $signed(req_i.op1) >>> shamt;
            OP_SLT:  result = XLEN'($signed(req_i.op1) < $signed(req_i.op2));
            OP_SLTU: result = XLEN'(req_i.op1 < req_i.op2);
            default: result = '0;
        endcase
    end

    // write enable pulses the cycle after the request
    always_ff @(posedge clk) begin
        if (reset_i) begin
            we_o <= 1'b0;
        end else begin
            we_o <= req_i.req;
        end
    end

    always_ff @(posedge clk) begin
        if (req_i.req) begin
            waddr_o <= req_i.rd;
            wdata_o <= result;
        end
    end

endmodule

// ==== rtl/exu_bru.sv ====
module exu_bru
    import exu_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic            valid_i,
    input  exu_op_e         op_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] rs1_i,
    input  logic [XLEN-1:0] rs2_i,
    input  logic [XLEN-1:0] imm_i,
    input  logic            int_assert_i,
    input  logic [XLEN-1:0] int_addr_i,
    output logic            jump_flag_o,
    output logic [XLEN-1:0] jump_addr_o
);

    logic            eq;
    logic            lt_s;
    logic            lt_u;
    logic            taken;
    logic [XLEN-1:0] target;

    assign eq   = (rs1_i == rs2_i);
    assign lt_s = $signed(rs1_i) < $signed(rs2_i);
    assign lt_u = rs1_i < rs2_i;

    always_comb begin
        case (op_i)
            OP_BEQ:          taken = eq;
            OP_BNE:          taken = ~eq;
            OP_BLT:          taken = lt_s;
            OP_BGE:          taken = ~lt_s;
            OP_BLTU:         taken = lt_u;
            OP_BGEU:         taken = ~lt_u;
            OP_JAL, OP_JALR: taken = 1'b1;
            default:         taken = 1'b0;
        endcase
    end

    // jalr target has bit 0 cleared
    assign target = (op_i == OP_JALR) ? ((rs1_i + imm_i) & ~XLEN'(1)) : (pc_i + imm_i);

    // interrupt wins over any branch
    assign jump_flag_o = int_assert_i | (valid_i & taken);
    assign jump_addr_o = int_assert_i ? int_addr_i : target;

endmodule

// ==== rtl/exu_muldiv.sv ====
module exu_muldiv
    import exu_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic                  clk,
    input  logic                  reset_i,
    exu_req_if.unit               req_i,
    input  logic                  int_assert_i,
    output logic                  stall_o,
    output logic                  we_o,
    output logic [REG_ADDR_W-1:0] waddr_o,
    output logic [XLEN-1:0]       wdata_o
);

    localparam int CNT_W = $clog2(XLEN);

    typedef enum logic [1:0] {
        MD_IDLE,
        MD_CALC,
        MD_DONE
    } md_state_e;

    md_state_e             state;
    logic [CNT_W-1:0]      cnt;
    exu_op_e               op_q;
    logic [REG_ADDR_W-1:0] rd_q;
    logic [2*XLEN-1:0]     acc;       // {hi, lo}, product or {rem, quo}
    logic [XLEN-1:0]       b_q;       // multiplicand or divisor
    logic                  is_div;
    logic                  div_zero;
    logic [XLEN:0]         add_sum;
    logic [XLEN:0]         sub_diff;
    logic [2*XLEN-1:0]     acc_next;

    assign is_div   = (op_q == OP_DIVU) || (op_q == OP_REMU);
    assign div_zero = is_div && (b_q == '0);

    // one shift-add or restoring step per cycle
    always_comb begin
        add_sum  = {1'b0, acc[2*XLEN-1:XLEN]} + {1'b0, b_q & {XLEN{acc[0]}}};
        sub_diff = acc[2*XLEN-1:XLEN-1] - {1'b0, b_q};
        if (is_div) begin
            if (!sub_diff[XLEN]) begin
                acc_next = {sub_diff[XLEN-1:0], acc[XLEN-2:0], 1'b1};
            end else begin
                acc_next = {acc[2*XLEN-2:0], 1'b0};  // restore, shift only
            end
        end else begin
            acc_next = {add_sum, acc[XLEN-1:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state <= MD_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                MD_IDLE: begin
                    cnt <= '0;
                    if (req_i.req && !int_assert_i) begin
                        state <= MD_CALC;
                    end
                end
                MD_CALC: begin
                    cnt <= cnt + 1'b1;
                    if (int_assert_i) begin
                        state <= MD_IDLE;  // abort, nothing written back
                    end else if (div_zero || cnt == CNT_W'(XLEN - 1)) begin
                        state <= MD_DONE;
                    end
                end
                MD_DONE: state <= MD_IDLE;
                default: state <= MD_IDLE;
            endcase
        end
    end

    // operands latched at acceptance
    always_ff @(posedge clk) begin
        if (state == MD_IDLE && req_i.req) begin
            op_q <= req_i.op;
            rd_q <= req_i.rd;
            if (req_i.op inside {OP_DIVU, OP_REMU}) begin
                b_q <= req_i.op2;
                // divide by zero gives quo all ones, rem = dividend
                acc <= (req_i.op2 == '0) ? {req_i.op1, {XLEN{1'b1}}}
                                         : {{XLEN{1'b0}}, req_i.op1};
            end else begin
                b_q <= req_i.op1;
                acc <= {{XLEN{1'b0}}, req_i.op2};
            end
        end else if (state == MD_CALC && !div_zero) begin
            acc <= acc_next;
        end
    end

    assign stall_o = (state == MD_CALC);
    assign we_o    = (state == MD_DONE);
    assign waddr_o = rd_q;
    assign wdata_o = (op_q == OP_MULHU || op_q == OP_REMU) ? acc[2*XLEN-1:XLEN]
                                                           : acc[XLEN-1:0];

endmodule

// ==== rtl/exu.sv ====
module exu
    import exu_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic                  clk,
    input  logic                  reset_i,
    input  logic                  valid_i,
    input  exu_op_e               op_i,
    input  logic [XLEN-1:0]       pc_i,
    input  logic [XLEN-1:0]       rs1_i,
    input  logic [XLEN-1:0]       rs2_i,
    input  logic [XLEN-1:0]       imm_i,
    input  logic [REG_ADDR_W-1:0] rd_i,
    input  logic                  int_assert_i,
    input  logic [XLEN-1:0]       int_addr_i,
    output logic                  alu_we_o,
    output logic [REG_ADDR_W-1:0] alu_waddr_o,
    output logic [XLEN-1:0]       alu_wdata_o,
    output logic                  md_we_o,
    output logic [REG_ADDR_W-1:0] md_waddr_o,
    output logic [XLEN-1:0]       md_wdata_o,
    output logic                  stall_flag_o,
    output logic                  jump_flag_o,
    output logic [XLEN-1:0]       jump_addr_o
);

    exu_req_if #(.XLEN(XLEN)) alu_req ();
    exu_req_if #(.XLEN(XLEN)) md_req ();

    exu_dispatch #(.XLEN(XLEN)) u_dispatch (
        .valid_i(valid_i),
        .op_i   (op_i),
        .pc_i   (pc_i),
        .rs1_i  (rs1_i),
        .rs2_i  (rs2_i),
        .imm_i  (imm_i),
        .rd_i   (rd_i),
        .alu_o  (alu_req.disp),
        .md_o   (md_req.disp)
    );

    exu_alu #(.XLEN(XLEN)) u_alu (
        .clk    (clk),
        .reset_i(reset_i),
        .req_i  (alu_req.unit),
        .we_o   (alu_we_o),
        .waddr_o(alu_waddr_o),
        .wdata_o(alu_wdata_o)
    );

    // branch unit sees raw operands, not the dispatched pair
    exu_bru #(.XLEN(XLEN)) u_bru (
        .valid_i     (valid_i),
        .op_i        (op_i),
        .pc_i        (pc_i),
        .rs1_i       (rs1_i),
        .rs2_i       (rs2_i),
        .imm_i       (imm_i),
        .int_assert_i(int_assert_i),
        .int_addr_i  (int_addr_i),
        .jump_flag_o (jump_flag_o),
        .jump_addr_o (jump_addr_o)
    );

    exu_muldiv #(.XLEN(XLEN)) u_muldiv (
        .clk         (clk),
        .reset_i     (reset_i),
        .req_i       (md_req.unit),
        .int_assert_i(int_assert_i),
        .stall_o     (stall_flag_o),  // only stall source left
        .we_o        (md_we_o),
        .waddr_o     (md_waddr_o),
        .wdata_o     (md_wdata_o)
    );

endmodule

// ==== tb/tb_clk_gen.sv ====
module tb_clk_gen #(
    parameter int PERIOD     = 10,
    parameter int RST_CYCLES = 4
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    initial begin
        reset_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_o);
        reset_o <= 1'b0;  // released on an edge, seen as sync
    end

endmodule

// ==== tb/tb_exu.sv ====
module tb_exu
    import exu_pkg::*;
();

    localparam int XLEN     = 32;
    localparam int N_ITEMS  = 100;  // rough instruction count, all tests
    localparam int WD_LIMIT = N_ITEMS * (XLEN + 10) + 200;
    localparam exu_op_e ALU_OPS [11] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLL,
                                        OP_SRL, OP_SRA, OP_SLT, OP_SLTU, OP_ADDI};
    localparam exu_op_e BR_OPS [6] = '{OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
    localparam exu_op_e MD_OPS [4] = '{OP_MUL, OP_MULHU, OP_DIVU, OP_REMU};

    logic                  clk;
    logic                  reset_i;
    logic                  valid_i;
    exu_op_e               op_i;
    logic [XLEN-1:0]       pc_i;
    logic [XLEN-1:0]       rs1_i;
    logic [XLEN-1:0]       rs2_i;
    logic [XLEN-1:0]       imm_i;
    logic [REG_ADDR_W-1:0] rd_i;
    logic                  int_assert_i;
    logic [XLEN-1:0]       int_addr_i;
    logic                  alu_we_o;
    logic [REG_ADDR_W-1:0] alu_waddr_o;
    logic [XLEN-1:0]       alu_wdata_o;
    logic                  md_we_o;
    logic [REG_ADDR_W-1:0] md_waddr_o;
    logic [XLEN-1:0]       md_wdata_o;
    logic                  stall_flag_o;
    logic                  jump_flag_o;
    logic [XLEN-1:0]       jump_addr_o;
    int                    errors = 0;
    int                    checks = 0;
    int                    tests  = 0;

    tb_clk_gen #(.PERIOD(10), .RST_CYCLES(4)) u_clk_gen (.clk_o(clk), .reset_o(reset_i));

    exu #(.XLEN(XLEN)) i_dut (.*);

    function automatic logic [XLEN-1:0] rnd();
        return XLEN'($urandom);
    endfunction

    // expected values straight from the isa rules
    function automatic logic [XLEN-1:0] alu_model(exu_op_e op, logic [XLEN-1:0] a,
                                                  logic [XLEN-1:0] b);
        logic [XLEN-1:0] r;
        r = '0;
        case (op)
            OP_ADD, OP_ADDI: r = a + b;
            OP_SUB:  r = a - b;
            OP_AND:  r = a & b;
            OP_OR:   r = a | b;
            OP_XOR:  r = a ^ b;
            OP_SLL:  r = a << b[4:0];
            OP_SRL:  r = a >> b[4:0];
            OP_SRA: begin
                r = a >> b[4:0];
                if (a[XLEN-1]) r = r | ~({XLEN{1'b1}} >> b[4:0]);  // sign fill
            end
            OP_SLT:  r = XLEN'((a[XLEN-1] != b[XLEN-1]) ? a[XLEN-1] : (a < b));
            OP_SLTU: r = XLEN'(a < b);
            default: r = '0;
        endcase
        return r;
    endfunction

    function automatic logic br_model(exu_op_e op, logic [XLEN-1:0] a, logic [XLEN-1:0] b);
        logic lt;
        lt = (a[XLEN-1] != b[XLEN-1]) ? a[XLEN-1] : (a < b);
        case (op)
            OP_BEQ:  return a == b;
            OP_BNE:  return a != b;
            OP_BLT:  return lt;
            OP_BGE:  return !lt;
            OP_BLTU: return a < b;
            OP_BGEU: return a >= b;
            default: return 1'b1;  // jal, jalr
        endcase
    endfunction

    function automatic logic [XLEN-1:0] md_model(exu_op_e op, logic [XLEN-1:0] a,
                                                 logic [XLEN-1:0] b);
        logic [2*XLEN-1:0] p;
        p = (2*XLEN)'(a) * (2*XLEN)'(b);
        case (op)
            OP_MUL:   return p[XLEN-1:0];
            OP_MULHU: return p[2*XLEN-1:XLEN];
            OP_DIVU:  return (b == '0) ? {XLEN{1'b1}} : a / b;
            default:  return (b == '0) ? a : a % b;
        endcase
    endfunction

    task automatic check(input string name, input logic [XLEN-1:0] exp,
                         input logic [XLEN-1:0] got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERR %s expected %h got %h", name, exp, got);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERR %s expected %h got %h", name, exp, got);
        end
    endtask

    task automatic drive(input exu_op_e op, input logic [XLEN-1:0] a, input logic [XLEN-1:0] b,
                         input logic [XLEN-1:0] imm, input logic [XLEN-1:0] pc,
                         input logic [REG_ADDR_W-1:0] rd);
        @(negedge clk);
        valid_i = 1'b1;
        op_i    = op;
        rs1_i   = a;
        rs2_i   = b;
        imm_i   = imm;
        pc_i    = pc;
        rd_i    = rd;
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %s finished, errors so far %0d", name, errors);
    endtask

    task automatic alu_one(input exu_op_e op, input logic [XLEN-1:0] a,
                           input logic [XLEN-1:0] b);
        logic [XLEN-1:0]       imm;
        logic [XLEN-1:0]       exp;
        logic [REG_ADDR_W-1:0] rd;
        imm = rnd();
        rd  = REG_ADDR_W'($urandom);
        exp = alu_model(op, a, (op == OP_ADDI) ? imm : b);
        drive(op, a, b, imm, rnd(), rd);
        #1 check_bit("jump_flag_o", 1'b0, jump_flag_o);
        @(negedge clk);
        valid_i = 1'b0;
        check_bit("alu_we_o", 1'b1, alu_we_o);
        check("alu_waddr_o", XLEN'(rd), XLEN'(alu_waddr_o));
        check("alu_wdata_o", exp, alu_wdata_o);
        @(negedge clk);
        check_bit("alu_we_o", 1'b0, alu_we_o);  // single pulse
    endtask

    // plain branches and jumps, jumps also write the link register
    task automatic branch_one(input exu_op_e op, input logic [XLEN-1:0] a,
                              input logic [XLEN-1:0] b);
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       imm;
        logic [XLEN-1:0]       target;
        logic                  link;
        logic                  taken;
        logic [REG_ADDR_W-1:0] rd;
        pc     = rnd() & ~XLEN'(3);
        imm    = $signed(rnd()) >>> 20;
        link   = (op == OP_JAL) || (op == OP_JALR);
        taken  = br_model(op, a, b);
        target = (op == OP_JALR) ? a + imm : pc + imm;
        if (op == OP_JALR) target[0] = 1'b0;
        rd     = REG_ADDR_W'($urandom);
        drive(op, a, b, imm, pc, rd);
        #1 check_bit("jump_flag_o", taken, jump_flag_o);
        if (taken) check("jump_addr_o", target, jump_addr_o);
        @(negedge clk);
        valid_i = 1'b0;
        check_bit("alu_we_o", link, alu_we_o);
        if (link) begin
            check("alu_waddr_o", XLEN'(rd), XLEN'(alu_waddr_o));
            check("alu_wdata_o", pc + XLEN'(4), alu_wdata_o);
        end
    endtask

    task automatic run_md(input exu_op_e op, input logic [XLEN-1:0] a,
                          input logic [XLEN-1:0] b, input bit overlap);
        logic [XLEN-1:0]       exp;
        logic [XLEN-1:0]       x;
        logic [XLEN-1:0]       y;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rd_alu;
        int                    cyc;
        exp    = md_model(op, a, b);
        rd     = REG_ADDR_W'($urandom);
        rd_alu = rd + 1'b1;
        x      = rnd();
        y      = rnd();
        cyc    = 0;
        drive(op, a, b, '0, '0, rd);
        @(negedge clk);
        valid_i = 1'b0;
        check_bit("stall_flag_o", 1'b1, stall_flag_o);
        if (overlap) begin  // alu add while the divide is busy
            drive(OP_ADD, x, y, '0, '0, rd_alu);
            @(negedge clk);
            valid_i = 1'b0;
            check_bit("alu_we_o", 1'b1, alu_we_o);
            check("alu_waddr_o", XLEN'(rd_alu), XLEN'(alu_waddr_o));
            check("alu_wdata_o", x + y, alu_wdata_o);
        end
        while (md_we_o !== 1'b1 && cyc < XLEN + 8) begin
            check_bit("stall_flag_o", 1'b1, stall_flag_o);
            @(negedge clk);
            cyc++;
        end
        if (md_we_o !== 1'b1) begin
            errors++;
            $display("md_we_o never came for %s after %0d cycles", op.name(), cyc);
        end else begin
            check_bit("stall_flag_o", 1'b0, stall_flag_o);
            check("md_waddr_o", XLEN'(rd), XLEN'(md_waddr_o));
            check("md_wdata_o", exp, md_wdata_o);
            @(negedge clk);
            check_bit("md_we_o", 1'b0, md_we_o);
        end
    endtask

    task automatic irq_test();
        logic [XLEN-1:0] addr;
        addr = rnd();
        @(negedge clk);
        int_assert_i = 1'b1;
        int_addr_i   = addr;
        #1 check_bit("jump_flag_o", 1'b1, jump_flag_o);
        check("jump_addr_o", addr, jump_addr_o);
        drive(OP_BEQ, XLEN'(1), XLEN'(2), XLEN'(16), rnd(), '0);  // not taken, irq still wins
        #1 check_bit("jump_flag_o", 1'b1, jump_flag_o);
        check("jump_addr_o", addr, jump_addr_o);
        @(negedge clk);
        valid_i      = 1'b0;
        int_assert_i = 1'b0;
        #1 check_bit("jump_flag_o", 1'b0, jump_flag_o);
        // abort a multiply half way
        drive(OP_MUL, rnd(), rnd(), '0, '0, 5'd3);
        @(negedge clk);
        valid_i = 1'b0;
        check_bit("stall_flag_o", 1'b1, stall_flag_o);
        repeat (3) @(negedge clk);
        int_assert_i = 1'b1;
        @(negedge clk);
        int_assert_i = 1'b0;
        check_bit("stall_flag_o", 1'b0, stall_flag_o);
        repeat (XLEN + 4) begin
            @(negedge clk);
            check_bit("md_we_o", 1'b0, md_we_o);
        end
    endtask

    // stall and write-back never overlap
    always @(negedge clk) begin
        if (!reset_i) begin
            assert (!(stall_flag_o && md_we_o)) else begin
                errors++;
                $display("stall_flag_o still high while md_we_o pulses");
            end
        end
    end

    initial begin
        repeat (WD_LIMIT) @(posedge clk);
        $display("watchdog expired, the run did not finish in time");
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        void'($urandom(32'hd1f70567));
        valid_i      = 1'b1;  // requests held in reset must be dropped
        op_i         = OP_ADD;
        pc_i         = '0;
        rs1_i        = '0;
        rs2_i        = '0;
        imm_i        = '0;
        rd_i         = '0;
        int_assert_i = 1'b0;
        int_addr_i   = '0;
        @(posedge clk);
        @(negedge clk);
        check_bit("alu_we_o", 1'b0, alu_we_o);
        op_i = OP_MUL;
        wait (!reset_i);
        @(negedge clk);
        check_bit("alu_we_o", 1'b0, alu_we_o);
        check_bit("md_we_o", 1'b0, md_we_o);
        check_bit("stall_flag_o", 1'b0, stall_flag_o);
        check_bit("jump_flag_o", 1'b0, jump_flag_o);
        valid_i = 1'b0;
        end_test("reset");
        foreach (ALU_OPS[i]) begin
            repeat (4) alu_one(ALU_OPS[i], rnd(), rnd());
        end
        end_test("alu");
        foreach (BR_OPS[i]) begin
            a = rnd();
            b = rnd();
            branch_one(BR_OPS[i], a, a);
            branch_one(BR_OPS[i], a, b);
            branch_one(BR_OPS[i], b, a);
        end
        branch_one(OP_JAL, rnd(), rnd());
        branch_one(OP_JALR, rnd(), rnd());
        end_test("branch");
        foreach (MD_OPS[i]) begin
            repeat (3) run_md(MD_OPS[i], rnd(), rnd(), 1'b0);
        end
        run_md(OP_DIVU, rnd(), rnd() & XLEN'(32'hff), 1'b0);  // small divisor
        run_md(OP_DIVU, rnd(), '0, 1'b0);
        run_md(OP_REMU, rnd(), '0, 1'b0);
        end_test("muldiv");
        run_md(OP_DIVU, rnd(), rnd() >> 8, 1'b1);
        end_test("overlap");
        irq_test();
        end_test("interrupt");
        $display("tests %0d checks %0d errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== exu.f ====
rtl/exu_pkg.sv
rtl/exu_req_if.sv
rtl/exu_dispatch.sv
rtl/exu_alu.sv
rtl/exu_bru.sv
rtl/exu_muldiv.sv
rtl/exu.sv
tb/tb_clk_gen.sv
tb/tb_exu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_exu
FILELIST  ?= exu.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^NO ERRORS$$"

clean:
	rm -rf $(BUILD_DIR)
